/* verilog/commu_m_pkg.sv */
// shared fx bus types, register map and reset values for the communication module slave
package commu_m_pkg;

	// ------------------------------
	// fx bus
	// ------------------------------

	// write side, strobe with address and data byte
	typedef struct packed {
		logic        wr;
		logic [15:0] waddr;
		logic [7:0]  data;
	} fx_wr_t;

	// read side, strobe with address only
	typedef struct packed {
		logic        rd;
		logic [15:0] raddr;
	} fx_rd_t;

	// ------------------------------
	// register select
	// ------------------------------

	// target of one access, debug bytes share one select
	typedef enum logic [2:0] {
		sel_none,
		sel_id,
		sel_status,
		sel_tp,
		sel_dbg
	} reg_sel_e;

	// decoded access, hit already includes strobe and module match
	typedef struct packed {
		logic     hit;
		reg_sel_e sel;
		logic [2:0] dbg_idx;
	} reg_access_t;

	// ------------------------------
	// register map
	// ------------------------------

	localparam logic [7:0] ofs_id       = 8'h00;
	localparam logic [7:0] ofs_status   = 8'h30;
	localparam logic [7:0] ofs_tp       = 8'h40;
	localparam logic [7:0] ofs_dbg_base = 8'h80;

	// debug scratch window is ofs_dbg_base .. ofs_dbg_base + num_dbg - 1
	localparam int num_dbg = 8;

	// reset values
	localparam logic [7:0] rst_tp       = 8'h03;
	// debug byte i comes up as rst_dbg_base + i
	localparam logic [7:0] rst_dbg_base = 8'h80;

endpackage

/* verilog/fx_addr_decode.sv */
// fx bus address decode, turns write and read strobes into register accesses for this module
`timescale 1ns/1ps

module fx_addr_decode import commu_m_pkg::*; (
	input  fx_wr_t      fx_w,
	input  fx_rd_t      fx_r,
	input  logic [5:0]  mod_id,
	output reg_access_t wacc,
	output reg_access_t racc,
	output logic [7:0]  wdata
);

	// ------------------------------
	// one side of the bus
	// ------------------------------

	// bits 13:8 pick the module, bits 7:0 the register
	// bits 15:14 play no part in the match
	function automatic reg_access_t classify(
		input logic        strobe,
		input logic [15:0] addr,
		input logic [5:0]  id
	);
		reg_access_t acc;
		logic [7:0]  ofs;
		logic [7:0]  dbg_ofs;

		ofs     = addr[7:0];
		dbg_ofs = ofs - ofs_dbg_base;

		acc.hit     = strobe && (addr[13:8] == id);
		acc.sel     = sel_none;
		acc.dbg_idx = 3'd0;

		if (ofs == ofs_id) begin
			acc.sel = sel_id;
		end else if (ofs == ofs_status) begin
			acc.sel = sel_status;
		end else if (ofs == ofs_tp) begin
			acc.sel = sel_tp;
		end else if (dbg_ofs < 8'(num_dbg)) begin
			// inside the scratch window, low bits give the byte
			acc.sel     = sel_dbg;
			acc.dbg_idx = dbg_ofs[2:0];
		end

		return acc;
	endfunction

	// ------------------------------
	// write and read sides
	// ------------------------------

	always_comb begin
		wacc = classify(fx_w.wr, fx_w.waddr, mod_id);
		racc = classify(fx_r.rd, fx_r.raddr, mod_id);
	end

	// data byte travels alongside the write access
	assign wdata = fx_w.data;

endmodule

/* verilog/commu_m_reg.sv */
// register storage of the module, holds cfg_tp and the debug scratch bytes and executes writes
`timescale 1ns/1ps

module commu_m_reg import commu_m_pkg::*; (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  reg_access_t                   wacc,
	input  logic [7:0]                    wdata,
	output logic [7:0]                    cfg_tp,
	output logic [num_dbg-1:0][7:0]       dbg_regs
);

	// ------------------------------
	// write enables
	// ------------------------------

	logic tp_we;
	logic dbg_we;

	// id, status and unmapped offsets are never written
	always_comb begin
		tp_we  = 1'b0;
		dbg_we = 1'b0;
		if (wacc.hit) begin
			case (wacc.sel)
				sel_tp: begin
					tp_we = 1'b1;
				end
				sel_dbg: begin
					dbg_we = 1'b1;
				end
				default: begin
					tp_we  = 1'b0;
					dbg_we = 1'b0;
				end
			endcase
		end
	end

	// ------------------------------
	// configuration byte
	// ------------------------------

	// new value shows on the output the cycle after the write edge
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg_tp <= rst_tp;
		end else if (tp_we) begin
			cfg_tp <= wdata;
		end
	end

	// ------------------------------
	// debug scratch bytes
	// ------------------------------

	// each byte resets to its own value, base plus index
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_dbg; i++) begin
				dbg_regs[i] <= rst_dbg_base + 8'(i);
			end
		end else if (dbg_we) begin
			dbg_regs[wacc.dbg_idx] <= wdata;
		end
	end

endmodule

/* verilog/fx_read_return.sv */
// registered read return of the module, puts the selected byte on fx_q for one cycle
`timescale 1ns/1ps

module fx_read_return import commu_m_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  reg_access_t             racc,
	input  logic [5:0]              mod_id,
	input  logic [7:0]              stu_buf_rdy,
	input  logic [7:0]              cfg_tp,
	input  logic [num_dbg-1:0][7:0] dbg_regs,
	output logic [7:0]              fx_q
);

	// ------------------------------
	// source select
	// ------------------------------

	logic [7:0] rd_byte;

	// status is taken live, sampled at the read edge
	always_comb begin
		case (racc.sel)
			sel_id: begin
				rd_byte = {2'b00, mod_id};
			end
			sel_status: begin
				rd_byte = stu_buf_rdy;
			end
			sel_tp: begin
				rd_byte = cfg_tp;
			end
			sel_dbg: begin
				rd_byte = dbg_regs[racc.dbg_idx];
			end
			default: begin
				// unmapped offset reads back zero
				rd_byte = 8'h00;
			end
		endcase
	end

	// ------------------------------
	// return register
	// ------------------------------

	// loads on a hit, clears otherwise, so the byte lasts exactly one cycle
	// registers before a same-cycle write lands, so old value is returned
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fx_q <= 8'h00;
		end else if (racc.hit) begin
			fx_q <= rd_byte;
		end else begin
			fx_q <= 8'h00;
		end
	end

endmodule

/* verilog/commu_m_top.sv */
// top level of the fx bus register slave, wires decode, storage and read return together
`timescale 1ns/1ps

module commu_m_top import commu_m_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	// fx bus
	input  fx_wr_t     fx_w,
	input  fx_rd_t     fx_r,
	output logic [7:0] fx_q,
	// module side
	input  logic [5:0] mod_id,
	input  logic [7:0] stu_buf_rdy,
	output logic [7:0] cfg_tp
);

	// ------------------------------
	// internal wires
	// ------------------------------

	reg_access_t             wacc;
	reg_access_t             racc;
	logic [7:0]              wdata;
	logic [num_dbg-1:0][7:0] dbg_regs;

	// ------------------------------
	// decode
	// ------------------------------

	fx_addr_decode i_fx_addr_decode (
		.fx_w   (fx_w),
		.fx_r   (fx_r),
		.mod_id (mod_id),
		.wacc   (wacc),
		.racc   (racc),
		.wdata  (wdata)
	);

	// ------------------------------
	// storage
	// ------------------------------

	commu_m_reg i_commu_m_reg (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wacc     (wacc),
		.wdata    (wdata),
		.cfg_tp   (cfg_tp),
		.dbg_regs (dbg_regs)
	);

	// read path sees register values from before this edge's write
	fx_read_return i_fx_read_return (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.racc        (racc),
		.mod_id      (mod_id),
		.stu_buf_rdy (stu_buf_rdy),
		.cfg_tp      (cfg_tp),
		.dbg_regs    (dbg_regs),
		.fx_q        (fx_q)
	);

endmodule

/* sim/commu_m_checker.sv */
// testbench checker, watches the DUT ports, runs a reference register model and counts mismatches
`timescale 1ns/1ps

module commu_m_checker import commu_m_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  fx_wr_t     fx_w,
	input  fx_rd_t     fx_r,
	input  logic [5:0] mod_id,
	input  logic [7:0] stu_buf_rdy,
	input  logic [7:0] fx_q,
	input  logic [7:0] cfg_tp,
	output int         check_count,
	output int         error_count
);

	// ------------------------------
	// reference model state
	// ------------------------------

	logic [7:0] tp_model;
	logic [7:0] dbg_model [num_dbg];
	// byte fx_q must show after the current edge
	logic [7:0] exp_q;
	int         checks = 0;
	int         errors = 0;

	assign check_count = checks;
	assign error_count = errors;

	// reset values 0x03 and 0x80 + i
	task automatic reset_model();
		tp_model = 8'h03;
		for (int i = 0; i < num_dbg; i++) begin
			dbg_model[i] = 8'h80 + 8'(i);
		end
		exp_q = 8'h00;
	endtask

	// byte a read of this offset returns, from register values before the edge
	function automatic logic [7:0] expected_read(input logic [7:0] ofs);
		if (ofs == 8'h00) begin
			return {2'b00, mod_id};
		end else if (ofs == 8'h30) begin
			return stu_buf_rdy;
		end else if (ofs == 8'h40) begin
			return tp_model;
		end else if (ofs[7:3] == 5'b10000) begin
			return dbg_model[ofs[2:0]];
		end
		return 8'h00;
	endfunction

	// id, status and unmapped offsets keep the model as it is
	task automatic apply_write(input logic [7:0] ofs, input logic [7:0] data);
		if (ofs == 8'h40) begin
			tp_model = data;
		end else if (ofs[7:3] == 5'b10000) begin
			dbg_model[ofs[2:0]] = data;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error at time %0t: %s expected 8'h%02h, actual 8'h%02h",
				$time, name, exp, act);
		end
	endtask

	// ------------------------------
	// per edge compare and update
	// ------------------------------

	// inputs are still the values sampled by the DUT at this edge
	always @(posedge clk_sys) begin
		logic [7:0] next_q;

		if (!rst_n) begin
			reset_model();
		end else begin
			check_byte("fx_q", exp_q, fx_q);
			check_byte("cfg_tp", tp_model, cfg_tp);
			next_q = 8'h00;
			if (fx_r.rd && (fx_r.raddr[13:8] == mod_id)) begin
				next_q = expected_read(fx_r.raddr[7:0]);
			end
			// write lands after the read has taken its old value
			if (fx_w.wr && (fx_w.waddr[13:8] == mod_id)) begin
				apply_write(fx_w.waddr[7:0], fx_w.data);
			end
			exp_q = next_q;
		end
	end

endmodule

/* sim/commu_m_tb.sv */
// testbench top for the fx bus register slave, drives seeded random bus traffic into the DUT
`timescale 1ns/1ps

module commu_m_tb import commu_m_pkg::*; ();

	localparam int num_cycles = 2000;
	localparam int phase_len  = 500;
	localparam int max_cycles = num_cycles + 100;

	logic       clk_sys;
	logic       rst_n;
	fx_wr_t     fx_w;
	fx_rd_t     fx_r;
	logic [5:0] mod_id;
	logic [7:0] stu_buf_rdy;
	logic [7:0] fx_q;
	logic [7:0] cfg_tp;
	int         check_count;
	int         error_count;
	int         cycle_count = 0;
	integer     seed;

	commu_m_top i_commu_m_top (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fx_w        (fx_w),
		.fx_r        (fx_r),
		.fx_q        (fx_q),
		.mod_id      (mod_id),
		.stu_buf_rdy (stu_buf_rdy),
		.cfg_tp      (cfg_tp)
	);

	commu_m_checker i_commu_m_checker (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.fx_w        (fx_w),
		.fx_r        (fx_r),
		.mod_id      (mod_id),
		.stu_buf_rdy (stu_buf_rdy),
		.fx_q        (fx_q),
		.cfg_tp      (cfg_tp),
		.check_count (check_count),
		.error_count (error_count)
	);

	// ------------------------------
	// clock and timeout
	// ------------------------------

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: bus traffic did not finish within %0d cycles", max_cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	// about 70 percent own id, offsets weighted toward the register map
	task automatic pick_addr(input logic [5:0] own_id, output logic [15:0] addr);
		logic [31:0] r;
		logic [5:0]  id;
		logic [7:0]  ofs;

		r  = $random(seed);
		id = (r[9:0] < 10'd717) ? own_id : own_id + 6'd1 + (r[15:10] % 6'd63);
		case (r[19:16])
			4'd0, 4'd1: ofs = ofs_id;
			4'd2, 4'd3: ofs = ofs_status;
			4'd4, 4'd5, 4'd6: ofs = ofs_tp;
			4'd13: ofs = 8'h88;
			4'd14: ofs = 8'h7f;
			4'd15: ofs = r[27:20];
			default: ofs = ofs_dbg_base + {5'd0, r[22:20]};
		endcase
		addr = {r[31:30], id, ofs};
	endtask

	task automatic bus_cycle(input logic [5:0] own_id);
		logic [31:0] r;
		logic [15:0] waddr;
		logic [15:0] raddr;

		r = $random(seed);
		pick_addr(own_id, waddr);
		pick_addr(own_id, raddr);
		@(posedge clk_sys);
		mod_id      <= own_id;
		stu_buf_rdy <= r[23:16];
		fx_w        <= '{wr: r[0], waddr: waddr, data: r[15:8]};
		fx_r        <= '{rd: (r[2:1] != 2'b00), raddr: raddr};
	endtask

	task automatic directed_read(input logic [15:0] addr);
		@(posedge clk_sys);
		fx_w <= '0;
		fx_r <= '{rd: 1'b1, raddr: addr};
	endtask

	initial begin
		logic [31:0] r;
		logic [5:0]  phase_id;

		seed        = 83938;
		rst_n       = 1'b0;
		fx_w        = '0;
		fx_r        = '0;
		mod_id      = 6'h15;
		stu_buf_rdy = 8'h00;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;

		// reset contents before any write
		for (int i = 0; i < num_dbg; i++) begin
			directed_read({2'b00, mod_id, ofs_dbg_base + 8'(i)});
		end
		directed_read({2'b00, mod_id, ofs_tp});

		// one module id per phase
		for (int p = 0; p < num_cycles / phase_len; p++) begin
			r        = $random(seed);
			phase_id = r[5:0];
			for (int c = 0; c < phase_len; c++) begin
				bus_cycle(phase_id);
			end
		end

		// idle so the last read reaches fx_q and gets compared
		repeat (2) begin
			@(posedge clk_sys);
			fx_w <= '0;
			fx_r <= '0;
		end
		@(posedge clk_sys);
		#1;
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (check_count == 0) begin
			$display("no comparisons were made, the checker never saw reset released");
		end
		if (error_count == 0 && check_count > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* commu_m_top.f */
verilog/commu_m_pkg.sv
verilog/fx_addr_decode.sv
verilog/commu_m_reg.sv
verilog/fx_read_return.sv
verilog/commu_m_top.sv
sim/commu_m_checker.sv
sim/commu_m_tb.sv

/* Makefile */
TOP := commu_m_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f commu_m_top.f -o $(TOP)

# a missing pass line in the log fails the target
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q -x "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
